/* src/fr_sram_pkg.sv */
// ----------------------------------------------------------
// shared opcode and sequencer state types plus default sizes
// for the register file / sram transfer subsystem
// ----------------------------------------------------------
`default_nettype none

package fr_sram_pkg;

   // command opcodes seen at the fr_sram command port
   typedef enum logic [2:0] {
      OP_IDLE       = 3'd0,  // no memory access, zero response
      OP_WR_SRAM    = 3'd1,
      OP_WR_FR      = 3'd2,
      OP_RD_SRAM    = 3'd3,
      OP_RD_FR      = 3'd4,
      OP_FR_TO_SRAM = 3'd5,  // copy fr word into sram
      OP_SRAM_TO_FR = 3'd6,  // copy sram word into fr
      OP_FR_CLEAR   = 3'd7   // zero every register
   } op_e;

   // bus_ctrl sequencer states
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,  // ready for a command
      ST_SRC  = 2'd1,  // waiting for tick, first strobe
      ST_DST  = 2'd2,  // capture, then write on tick
      ST_RESP = 2'd3   // one cycle response pulse
   } seq_state_e;

   localparam int DATA_W_DEF   = 32;
   localparam int FR_AW_DEF    = 5;  // 32 registers
   localparam int SRAM_AW_DEF  = 6;  // 64 words
   localparam int DIV_LOG2_DEF = 2;  // tick every 4 cycles

endpackage

`default_nettype wire

/* src/clk_div_tick.sv */
// ----------------------------------------------------------
// step tick generator, one cycle enable every 2**DIV_LOG2
// clocks, used by the sequencer in place of a divided clock
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module clk_div_tick #(
   parameter int DIV_LOG2 = fr_sram_pkg::DIV_LOG2_DEF  // must be at least 1
) (
   input  logic orig_clk,
   input  logic rst_n,
   output logic tick
);

   logic [DIV_LOG2-1:0] cnt;  // free running divider count

   always_ff @(posedge orig_clk) begin
      if (!rst_n) begin
         cnt <= '0;  // restart divider
      end else begin
         cnt <= cnt + 1'b1;  // wraps naturally
      end
   end

   // pulse on the last count before wrap
   assign tick = (cnt == {DIV_LOG2{1'b1}});

endmodule

`default_nettype wire

/* src/bus_ctrl.sv */
// ----------------------------------------------------------
// command sequencer, strobes fr and sram on ticks, muxes the
// read data into one transfer word and returns the response
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module bus_ctrl #(
   parameter int DATA_W  = fr_sram_pkg::DATA_W_DEF,
   parameter int FR_AW   = fr_sram_pkg::FR_AW_DEF,
   parameter int SRAM_AW = fr_sram_pkg::SRAM_AW_DEF
) (
   input  logic               orig_clk,
   input  logic               rst_n,
   input  logic               tick,
   input  logic               cmd_valid,
   output logic               cmd_ready,
   input  fr_sram_pkg::op_e   cmd_op,
   input  logic [FR_AW-1:0]   cmd_fr_addr,
   input  logic [SRAM_AW-1:0] cmd_sram_addr,
   input  logic [DATA_W-1:0]  cmd_data,
   output logic               rsp_valid,
   output fr_sram_pkg::op_e   rsp_op,
   output logic [DATA_W-1:0]  rsp_data,
   output logic               fr_we,
   output logic               fr_re,
   output logic               fr_clr,
   output logic [FR_AW-1:0]   fr_addr,
   output logic [DATA_W-1:0]  fr_wdata,
   input  logic [DATA_W-1:0]  fr_rdata,
   output logic               sram_we,
   output logic               sram_re,
   output logic [SRAM_AW-1:0] sram_addr,
   output logic [DATA_W-1:0]  sram_wdata,
   input  logic [DATA_W-1:0]  sram_rdata
);

   fr_sram_pkg::seq_state_e state;
   fr_sram_pkg::op_e        op_q;      // latched opcode
   logic [DATA_W-1:0]       xfer;      // shared write / response word
   logic                    cap_pend;  // copy read issued, data not yet taken
   logic                    is_copy;
   logic                    src_stb;   // first access of a command
   logic                    dst_stb;   // destination write of a copy

   assign is_copy = (op_q == fr_sram_pkg::OP_FR_TO_SRAM) ||
                    (op_q == fr_sram_pkg::OP_SRAM_TO_FR);
   assign src_stb = tick && (state == fr_sram_pkg::ST_SRC);
   assign dst_stb = tick && (state == fr_sram_pkg::ST_DST) && !cap_pend;

   // opcode to strobe decode
   always_comb begin
      fr_we   = 1'b0;
      fr_re   = 1'b0;
      fr_clr  = 1'b0;
      sram_we = 1'b0;
      sram_re = 1'b0;
      case (op_q)
         fr_sram_pkg::OP_WR_SRAM:    sram_we = src_stb;
         fr_sram_pkg::OP_WR_FR:      fr_we   = src_stb;
         fr_sram_pkg::OP_RD_SRAM:    sram_re = src_stb;
         fr_sram_pkg::OP_RD_FR:      fr_re   = src_stb;
         fr_sram_pkg::OP_FR_TO_SRAM: begin
            fr_re   = src_stb;  // source read
            sram_we = dst_stb;  // then write on a later tick
         end
         fr_sram_pkg::OP_SRAM_TO_FR: begin
            sram_re = src_stb;
            fr_we   = dst_stb;
         end
         fr_sram_pkg::OP_FR_CLEAR:   fr_clr  = src_stb;
         default: begin
            // OP_IDLE touches nothing
         end
      endcase
   end

   // sequencer
   always_ff @(posedge orig_clk) begin
      if (!rst_n) begin
         state    <= fr_sram_pkg::ST_IDLE;
         op_q     <= fr_sram_pkg::OP_IDLE;
         cap_pend <= 1'b0;
      end else begin
         case (state)
            fr_sram_pkg::ST_IDLE: begin
               if (cmd_valid) begin  // accept
                  op_q  <= cmd_op;
                  state <= fr_sram_pkg::ST_SRC;
               end
            end
            fr_sram_pkg::ST_SRC: begin
               if (tick && is_copy) begin
                  cap_pend <= 1'b1;
                  state    <= fr_sram_pkg::ST_DST;
               end else if (tick) begin
                  state <= fr_sram_pkg::ST_RESP;  // single access done
               end
            end
            fr_sram_pkg::ST_DST: begin
               if (cap_pend) begin
                  cap_pend <= 1'b0;  // data captured this cycle
               end else if (tick) begin
                  state <= fr_sram_pkg::ST_RESP;
               end
            end
            default: state <= fr_sram_pkg::ST_IDLE;  // ST_RESP lasts one cycle
         endcase
      end
   end

   // addresses and transfer word
   always_ff @(posedge orig_clk) begin
      if (cmd_valid && cmd_ready) begin
         fr_addr   <= cmd_fr_addr;
         sram_addr <= cmd_sram_addr;
         xfer      <= cmd_data;
      end else if ((state == fr_sram_pkg::ST_DST) && cap_pend) begin
         // read data mux in place of the shared bus
         xfer <= (op_q == fr_sram_pkg::OP_FR_TO_SRAM) ? fr_rdata : sram_rdata;
      end
   end

   assign fr_wdata   = xfer;
   assign sram_wdata = xfer;

   // response word, read data lands during ST_RESP
   always_comb begin
      case (op_q)
         fr_sram_pkg::OP_RD_SRAM:  rsp_data = sram_rdata;
         fr_sram_pkg::OP_RD_FR:    rsp_data = fr_rdata;
         fr_sram_pkg::OP_IDLE:     rsp_data = '0;
         fr_sram_pkg::OP_FR_CLEAR: rsp_data = '0;
         default:                  rsp_data = xfer;  // written or moved word
      endcase
   end

   assign rsp_valid = (state == fr_sram_pkg::ST_RESP);
   assign rsp_op    = op_q;  // echo
   assign cmd_ready = (state == fr_sram_pkg::ST_IDLE);

endmodule

`default_nettype wire

/* src/file_register.sv */
// ----------------------------------------------------------
// register file, one write port and one registered read port,
// cleared as a whole by reset or by the clr strobe
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module file_register #(
   parameter int DATA_W = fr_sram_pkg::DATA_W_DEF,
   parameter int FR_AW  = fr_sram_pkg::FR_AW_DEF
) (
   input  logic              orig_clk,
   input  logic              rst_n,
   input  logic              we,
   input  logic              re,
   input  logic              clr,
   input  logic [FR_AW-1:0]  addr,
   input  logic [DATA_W-1:0] wdata,
   output logic [DATA_W-1:0] rdata
);

   localparam int DEPTH = 2 ** FR_AW;

   logic [DATA_W-1:0] regs [DEPTH];  // register array

   // write port, clear wins over write
   always_ff @(posedge orig_clk) begin
      if (!rst_n || clr) begin
         for (int i = 0; i < DEPTH; i++) begin
            regs[i] <= '0;  // all entries in one cycle
         end
      end else if (we) begin
         regs[addr] <= wdata;
      end
   end

   // read port, held until the next re
   always_ff @(posedge orig_clk) begin
      if (re) begin
         rdata <= regs[addr];
      end
   end

endmodule

`default_nettype wire

/* src/sram.sv */
// ----------------------------------------------------------
// single port word memory, synchronous write on we and a
// registered read on re, contents not reset
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sram #(
   parameter int DATA_W  = fr_sram_pkg::DATA_W_DEF,
   parameter int SRAM_AW = fr_sram_pkg::SRAM_AW_DEF
) (
   input  logic               orig_clk,
   input  logic               we,
   input  logic               re,
   input  logic [SRAM_AW-1:0] addr,
   input  logic [DATA_W-1:0]  wdata,
   output logic [DATA_W-1:0]  rdata
);

   localparam int DEPTH = 2 ** SRAM_AW;

   logic [DATA_W-1:0] mem [DEPTH];  // word storage

   // write at the edge ending the strobe
   always_ff @(posedge orig_clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
   end

   // read data valid the cycle after re
   always_ff @(posedge orig_clk) begin
      if (re) begin
         rdata <= mem[addr];  // holds until next read
      end
   end

endmodule

`default_nettype wire

/* src/fr_sram.sv */
// ----------------------------------------------------------
// top level, tick divider, sequencer, register file and sram
// behind a valid/ready command port and a response pulse
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fr_sram #(
   parameter int DATA_W   = fr_sram_pkg::DATA_W_DEF,
   parameter int FR_AW    = fr_sram_pkg::FR_AW_DEF,
   parameter int SRAM_AW  = fr_sram_pkg::SRAM_AW_DEF,
   parameter int DIV_LOG2 = fr_sram_pkg::DIV_LOG2_DEF
) (
   input  logic               orig_clk,
   input  logic               rst_n,
   input  logic               cmd_valid,
   output logic               cmd_ready,
   input  fr_sram_pkg::op_e   cmd_op,
   input  logic [FR_AW-1:0]   cmd_fr_addr,
   input  logic [SRAM_AW-1:0] cmd_sram_addr,
   input  logic [DATA_W-1:0]  cmd_data,
   output logic               rsp_valid,
   output fr_sram_pkg::op_e   rsp_op,
   output logic [DATA_W-1:0]  rsp_data
);

   logic               tick;                 // step enable
   logic               fr_we, fr_re, fr_clr;
   logic [FR_AW-1:0]   fr_addr;
   logic [DATA_W-1:0]  fr_wdata, fr_rdata;
   logic               sram_we, sram_re;
   logic [SRAM_AW-1:0] sram_addr;
   logic [DATA_W-1:0]  sram_wdata, sram_rdata;

   clk_div_tick #(.DIV_LOG2(DIV_LOG2)) u_clk_div_tick (
      .orig_clk (orig_clk),
      .rst_n    (rst_n),
      .tick     (tick)
   );

   bus_ctrl #(.DATA_W(DATA_W), .FR_AW(FR_AW), .SRAM_AW(SRAM_AW)) u_bus_ctrl (
      .orig_clk (orig_clk),      .rst_n         (rst_n),         .tick       (tick),
      .cmd_valid(cmd_valid),     .cmd_ready     (cmd_ready),     .cmd_op     (cmd_op),
      .cmd_fr_addr(cmd_fr_addr), .cmd_sram_addr (cmd_sram_addr), .cmd_data   (cmd_data),
      .rsp_valid(rsp_valid),     .rsp_op        (rsp_op),        .rsp_data   (rsp_data),
      .fr_we    (fr_we),         .fr_re         (fr_re),         .fr_clr     (fr_clr),
      .fr_addr  (fr_addr),       .fr_wdata      (fr_wdata),      .fr_rdata   (fr_rdata),
      .sram_we  (sram_we),       .sram_re       (sram_re),       .sram_addr  (sram_addr),
      .sram_wdata(sram_wdata),   .sram_rdata    (sram_rdata)
   );

   // staging buffer
   file_register #(.DATA_W(DATA_W), .FR_AW(FR_AW)) u_file_register (
      .orig_clk (orig_clk), .rst_n (rst_n), .we (fr_we), .re (fr_re), .clr (fr_clr),
      .addr     (fr_addr),  .wdata (fr_wdata), .rdata (fr_rdata)
   );

   // consuming store
   sram #(.DATA_W(DATA_W), .SRAM_AW(SRAM_AW)) u_sram (
      .orig_clk (orig_clk),  .we (sram_we), .re (sram_re),
      .addr     (sram_addr), .wdata (sram_wdata), .rdata (sram_rdata)
   );

endmodule

`default_nettype wire

/* testbench/fr_sram_sva.sv */
// ----------------------------------------------------------
// strobe and handshake rules, bound into bus_ctrl
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fr_sram_sva (
   input logic                    orig_clk,
   input logic                    rst_n,
   input logic                    tick,
   input fr_sram_pkg::seq_state_e state,
   input logic                    cmd_ready,
   input logic                    rsp_valid,
   input logic                    fr_we,
   input logic                    fr_re,
   input logic                    fr_clr,
   input logic                    sram_we,
   input logic                    sram_re
);

   // every memory strobe sits on a step tick
   a_strobe_on_tick: assert property (@(posedge orig_clk) disable iff (!rst_n)
      (fr_we || fr_re || fr_clr || sram_we || sram_re) |-> tick)
      else $error("memory strobe outside a tick");

   a_sram_one_strobe: assert property (@(posedge orig_clk) disable iff (!rst_n)
      !(sram_we && sram_re))
      else $error("sram read and write strobes together");

   a_rsp_pulse: assert property (@(posedge orig_clk) disable iff (!rst_n)
      rsp_valid |=> !rsp_valid)  // single cycle pulse
      else $error("rsp_valid longer than one cycle");

   // busy sequencer keeps cmd_ready low until the response is out
   a_ready_after_rsp: assert property (@(posedge orig_clk) disable iff (!rst_n)
      (state != fr_sram_pkg::ST_IDLE && !rsp_valid) |=> !cmd_ready)
      else $error("cmd_ready rose before the response pulse");

endmodule

`default_nettype wire

/* testbench/tb_fr_sram.sv */
// ----------------------------------------------------------
// directed and random command tests for fr_sram, responses
// checked against model arrays of both memories
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_fr_sram;

   localparam int DATA_W     = fr_sram_pkg::DATA_W_DEF;
   localparam int FR_AW      = fr_sram_pkg::FR_AW_DEF;
   localparam int SRAM_AW    = fr_sram_pkg::SRAM_AW_DEF;
   localparam int CLK_PERIOD = 8;
   localparam int RST_CYCLES = 16;
   localparam int RSP_LIMIT  = 30;   // cycles allowed per handshake wait
   localparam int NUM_CMDS   = 70;   // directed plus random commands
   localparam int TIMEOUT_NS = (NUM_CMDS * 30 + RST_CYCLES) * CLK_PERIOD;

   logic orig_clk, rst_n, cmd_valid, cmd_ready, rsp_valid;
   fr_sram_pkg::op_e   cmd_op, rsp_op;
   logic [FR_AW-1:0]   cmd_fr_addr;
   logic [SRAM_AW-1:0] cmd_sram_addr;
   logic [DATA_W-1:0]  cmd_data, rsp_data;

   logic [DATA_W-1:0] fr_model   [2**FR_AW];
   logic [DATA_W-1:0] sram_model [2**SRAM_AW];
   bit                sram_known [2**SRAM_AW];  // sram has no reset
   int                errors, checks;
   logic [31:0]       lcg_state;

   fr_sram #(.DATA_W(DATA_W), .FR_AW(FR_AW), .SRAM_AW(SRAM_AW), .DIV_LOG2(2)) dut_i (
      .orig_clk(orig_clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
      .cmd_op(cmd_op), .cmd_fr_addr(cmd_fr_addr), .cmd_sram_addr(cmd_sram_addr),
      .cmd_data(cmd_data), .rsp_valid(rsp_valid), .rsp_op(rsp_op), .rsp_data(rsp_data)
   );

   bind bus_ctrl fr_sram_sva sva_i (
      .orig_clk(orig_clk), .rst_n(rst_n), .tick(tick), .state(state),
      .cmd_ready(cmd_ready), .rsp_valid(rsp_valid), .fr_we(fr_we), .fr_re(fr_re),
      .fr_clr(fr_clr), .sram_we(sram_we), .sram_re(sram_re)
   );

   always #(CLK_PERIOD / 2) orig_clk = ~orig_clk;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;  // classic lcg constants
      return lcg_state;
   endfunction

   // expected response word, then model update
   function automatic logic [DATA_W-1:0] model_step(input fr_sram_pkg::op_e op,
         input logic [FR_AW-1:0] fa, input logic [SRAM_AW-1:0] sa, input logic [DATA_W-1:0] d);
      logic [DATA_W-1:0] exp_w;
      exp_w = '0;  // idle and clear
      case (op)
         fr_sram_pkg::OP_WR_SRAM: begin
            exp_w = d;
            sram_model[sa] = d;
            sram_known[sa] = 1'b1;
         end
         fr_sram_pkg::OP_WR_FR: begin
            exp_w = d;
            fr_model[fa] = d;
         end
         fr_sram_pkg::OP_RD_SRAM: exp_w = sram_model[sa];
         fr_sram_pkg::OP_RD_FR:   exp_w = fr_model[fa];
         fr_sram_pkg::OP_FR_TO_SRAM: begin
            exp_w = fr_model[fa];  // moved word
            sram_model[sa] = exp_w;
            sram_known[sa] = 1'b1;
         end
         fr_sram_pkg::OP_SRAM_TO_FR: begin
            exp_w = sram_model[sa];
            fr_model[fa] = exp_w;
         end
         fr_sram_pkg::OP_FR_CLEAR: begin
            for (int i = 0; i < 2**FR_AW; i++) fr_model[i] = '0;
         end
         default: exp_w = '0;
      endcase
      return exp_w;
   endfunction

   task automatic check_word(input string sig, input logic [DATA_W-1:0] exp_w,
                             input logic [DATA_W-1:0] act_w);
      checks++;
      if (act_w !== exp_w) begin
         errors++;
         $display("[FAIL] t=%0t %s expected %h actual %h", $time, sig, exp_w, act_w);
      end
   endtask

   task automatic check_op(input string sig, input fr_sram_pkg::op_e exp_op,
                           input fr_sram_pkg::op_e act_op);
      checks++;
      if (act_op !== exp_op) begin
         errors++;
         $display("[FAIL] t=%0t %s expected %s actual %s", $time, sig,
                  exp_op.name(), act_op.name());
      end
   endtask

   // called 1 ns after a rising edge, returns at the same phase
   task automatic send_cmd(input fr_sram_pkg::op_e op, input logic [FR_AW-1:0] fa,
         input logic [SRAM_AW-1:0] sa, input logic [DATA_W-1:0] d,
         output fr_sram_pkg::op_e r_op, output logic [DATA_W-1:0] r_data, output bit got);
      int waited;
      cmd_valid     = 1'b1;
      cmd_op        = op;
      cmd_fr_addr   = fa;
      cmd_sram_addr = sa;
      cmd_data      = d;
      waited = 0;
      while (!cmd_ready && waited < RSP_LIMIT) begin  // busy, hold the command
         @(posedge orig_clk);
         #1;
         waited++;
      end
      @(posedge orig_clk);  // accepted here
      #1;
      cmd_valid = 1'b0;
      waited = 0;
      while (!rsp_valid && waited < RSP_LIMIT) begin
         @(posedge orig_clk);
         #1;
         waited++;
      end
      got    = rsp_valid;
      r_op   = rsp_op;
      r_data = rsp_data;
   endtask

   task automatic exec_cmd(input fr_sram_pkg::op_e op, input logic [FR_AW-1:0] fa,
                           input logic [SRAM_AW-1:0] sa, input logic [DATA_W-1:0] d);
      logic [DATA_W-1:0] exp_w, got_w;
      fr_sram_pkg::op_e  got_op;
      bit                got;
      exp_w = model_step(op, fa, sa, d);
      send_cmd(op, fa, sa, d, got_op, got_w, got);
      if (!got) begin
         errors++;
         $display("no response to %s command at t=%0t", op.name(), $time);
      end else begin
         check_op("rsp_op", op, got_op);
         check_word("rsp_data", exp_w, got_w);
      end
   endtask

   // reads after reset, clear leaves sram alone
   task automatic clear_fr();
      exec_cmd(fr_sram_pkg::OP_RD_FR, 5'd3, '0, '0);
      exec_cmd(fr_sram_pkg::OP_RD_FR, 5'd17, '0, '0);
      exec_cmd(fr_sram_pkg::OP_WR_FR, 5'd3, '0, 32'hdead_beef);
      exec_cmd(fr_sram_pkg::OP_WR_SRAM, '0, 6'd9, 32'h1234_5678);
      exec_cmd(fr_sram_pkg::OP_FR_CLEAR, '0, '0, 32'hffff_ffff);  // data ignored
      exec_cmd(fr_sram_pkg::OP_RD_FR, 5'd3, '0, '0);
      exec_cmd(fr_sram_pkg::OP_RD_SRAM, '0, 6'd9, '0);
   endtask

   task automatic sram_write_read();
      exec_cmd(fr_sram_pkg::OP_WR_SRAM, '0, 6'd5, 32'ha5a5_0f0f);
      exec_cmd(fr_sram_pkg::OP_RD_SRAM, '0, 6'd5, '0);
      exec_cmd(fr_sram_pkg::OP_WR_SRAM, '0, 6'd63, 32'h0bad_cafe);  // top word
      exec_cmd(fr_sram_pkg::OP_RD_SRAM, '0, 6'd63, '0);
      exec_cmd(fr_sram_pkg::OP_IDLE, '0, '0, 32'h5555_aaaa);
   endtask

   task automatic fr_write_read();
      for (int i = 0; i < 6; i++)
         exec_cmd(fr_sram_pkg::OP_WR_FR, FR_AW'(i * 5 + 1), '0, next_rand());
      for (int i = 0; i < 6; i++)
         exec_cmd(fr_sram_pkg::OP_RD_FR, FR_AW'(i * 5 + 1), '0, '0);
   endtask

   task automatic copy_fr_to_sram();
      exec_cmd(fr_sram_pkg::OP_WR_FR, 5'd12, '0, 32'hc0de_0012);
      exec_cmd(fr_sram_pkg::OP_FR_TO_SRAM, 5'd12, 6'd40, '0);
      exec_cmd(fr_sram_pkg::OP_RD_SRAM, '0, 6'd40, '0);
   endtask

   task automatic copy_sram_to_fr();
      exec_cmd(fr_sram_pkg::OP_WR_SRAM, '0, 6'd33, 32'h7e57_0033);
      exec_cmd(fr_sram_pkg::OP_SRAM_TO_FR, 5'd20, 6'd33, '0);
      exec_cmd(fr_sram_pkg::OP_RD_FR, 5'd20, '0, '0);
   endtask

   // mostly back to back, sometimes a short gap to move the tick phase
   task automatic random_mix();
      logic [31:0]        r;
      fr_sram_pkg::op_e   op;
      logic [FR_AW-1:0]   fa;
      logic [SRAM_AW-1:0] sa;
      for (int n = 0; n < 40; n++) begin
         r  = next_rand();
         op = fr_sram_pkg::op_e'(r[18:16]);
         fa = FR_AW'(r >> 8);
         sa = SRAM_AW'(r >> 20);
         if ((op == fr_sram_pkg::OP_RD_SRAM || op == fr_sram_pkg::OP_SRAM_TO_FR) &&
             !sram_known[sa]) op = fr_sram_pkg::OP_WR_SRAM;  // avoid unwritten words
         if (r[31]) begin  // upper bits, low lcg bits repeat
            repeat (r[29:28]) begin
               @(posedge orig_clk);
               #1;
            end
         end
         exec_cmd(op, fa, sa, next_rand());
      end
   endtask

   initial begin
      orig_clk = 1'b0;
      rst_n = 1'b0;
      cmd_valid = 1'b0;
      cmd_op = fr_sram_pkg::OP_IDLE;
      cmd_fr_addr = '0;
      cmd_sram_addr = '0;
      cmd_data = '0;
      errors = 0;
      checks = 0;
      lcg_state = 32'd28865;
      for (int i = 0; i < 2**FR_AW; i++) fr_model[i] = '0;  // reset clears fr
      for (int i = 0; i < 2**SRAM_AW; i++) begin
         sram_model[i] = '0;
         sram_known[i] = 1'b0;
      end
      repeat (RST_CYCLES) @(posedge orig_clk);
      #1 rst_n = 1'b1;
      clear_fr();
      sram_write_read();
      fr_write_read();
      copy_fr_to_sram();
      copy_sram_to_fr();
      random_mix();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired at t=%0t, tests did not finish", $time);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
src/fr_sram_pkg.sv
src/clk_div_tick.sv
src/bus_ctrl.sv
src/file_register.sv
src/sram.sv
src/fr_sram.sv
testbench/fr_sram_sva.sv
testbench/tb_fr_sram.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fr_sram testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f src.f \
   --top-module tb_fr_sram \
   -o tb_fr_sram_sim

# keep the log even when the simulation stops on an error
./obj_dir/tb_fr_sram_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
   echo "run_sim: pass"
   exit 0
else
   echo "run_sim: fail"
   exit 1
fi
